// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
TOP        = trig_tb
FILELIST   = trig_table.f
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/angle_reducer.sv ====
`timescale 1ns/1ps
`include "trig_params.svh"

module angle_reducer (
        input  logic                     clk,
        input  logic                     arst_n,
        input  logic                     start,
        input  logic [`TRIG_ANGLE_W-1:0] degrees,
        output logic [1:0]               quad,
        output logic [`TRIG_REF_W-1:0]   ref_angle,
        output logic                     in_range,
        output logic                     red_valid
);
        localparam logic [`TRIG_ANGLE_W-1:0] RIGHT = `TRIG_RIGHT_ANGLE;
        localparam logic [`TRIG_ANGLE_W-1:0] HALF  = 2 * `TRIG_RIGHT_ANGLE;
        localparam logic [`TRIG_ANGLE_W-1:0] THREE = 3 * `TRIG_RIGHT_ANGLE;
        localparam logic [`TRIG_ANGLE_W-1:0] FULL  = `TRIG_FULL_TURN;

        logic [1:0]               fold_quad;
        logic [`TRIG_ANGLE_W-1:0] fold_diff;
        logic                     fold_ok;

        always_comb
        begin
                fold_quad = 2'd0;
                fold_diff = '0;
                fold_ok   = 1'b1;
                if (degrees >= FULL)
                        fold_ok = 1'b0;            // out of range angles are not wrapped.
                else if (degrees >= THREE)
                begin
                        fold_quad = 2'd3;
                        fold_diff = FULL - degrees;
                end
                else if (degrees >= HALF)
                begin
                        fold_quad = 2'd2;
                        fold_diff = degrees - HALF;
                end
                else if (degrees >= RIGHT)
                begin
                        fold_quad = 2'd1;
                        fold_diff = HALF - degrees;   // 90 folds onto itself.
                end
                else
                        fold_diff = degrees;
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        red_valid <= 1'b0;
                        quad      <= 2'd0;
                        ref_angle <= '0;
                        in_range  <= 1'b0;
                end
                else
                begin
                        red_valid <= start;
                        // the folded angle is only captured on a start.
                        if (start)
                        begin
                                quad      <= fold_quad;
                                ref_angle <= fold_diff[`TRIG_REF_W-1:0];
                                in_range  <= fold_ok;
                        end
                end
        end

endmodule

// ==== logic/cosine_lut.sv ====
`timescale 1ns/1ps
`include "trig_params.svh"

module cosine_lut (
        input  logic                   clk,
        input  logic                   arst_n,
        input  logic [1:0]             quad,
        input  logic                   enable,
        input  logic [`TRIG_REF_W-1:0] ref_angle,
        output trig_pkg::ieee_double_u data
);
        import trig_pkg::*;

        localparam int           FRAC  = 96;
        localparam int           TERMS = 14;
        localparam logic [255:0] ONE_Q = 256'd1 << FRAC;
        // pi with 96 fraction bits.
        localparam logic [255:0] PI_Q  = 256'h3_243f6a88_85a308d3_13198a2e;

        // the table entries are worked out at elaboration with a fixed point
        // taylor series and packed into binary64 with round to nearest.
        function automatic logic [63:0] cos_bits(input int unsigned deg);
                logic [255:0] x;
                logic [255:0] x2;
                logic [255:0] term;
                logic [127:0] sum;
                logic [127:0] norm;
                logic [52:0]  mant;
                int unsigned  lead;
                int unsigned  biased;
                int           n;
                x    = (PI_Q * deg) / 180;
                x2   = (x * x) >> FRAC;
                term = ONE_Q;
                sum  = ONE_Q[127:0];
                for (n = 1; n <= TERMS; n++)
                begin
                        term = ((term * x2) >> FRAC) / ((2 * n - 1) * (2 * n));
                        if (n % 2 == 1)
                                sum = sum - term[127:0];  // may wrap, the final sum is positive.
                        else
                                sum = sum + term[127:0];
                end
                lead = 0;
                for (n = 0; n < 128; n++)
                begin
                        if (sum[n])
                                lead = n;
                end
                norm   = sum << (127 - lead);
                mant   = {1'b0, norm[126:75]} + {52'd0, norm[74]};
                biased = 1023 + lead - FRAC;
                if (mant[52])
                        biased = biased + 1;         // rounding carried into the exponent.
                return {1'b0, biased[10:0], mant[51:0]};
        endfunction

        logic [62:0]  rom [0:`TRIG_RIGHT_ANGLE];
        logic [62:0]  mag;
        logic         hit;
        ieee_double_u nxt;

        for (genvar k = 0; k < `TRIG_RIGHT_ANGLE; k++)
        begin : g_rom
                localparam logic [63:0] BITS = cos_bits(k);
                assign rom[k] = BITS[62:0];
        end

        // cosine of a right angle is exactly zero.
        assign rom[`TRIG_RIGHT_ANGLE] = '0;

        assign hit = (ref_angle <= `TRIG_RIGHT_ANGLE);

        always_comb
        begin
                mag = '0;
                if (hit)
                        mag = rom[ref_angle];

                nxt.raw         = {1'b0, mag};
                nxt.fields.sign = hit & ((quad == 2'd1) || (quad == 2'd2));  // zero gets a sign too.
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                        data <= '0;
                else if (enable)
                        data <= nxt;
        end

endmodule

// ==== logic/secant_lut.sv ====
`timescale 1ns/1ps
`include "trig_params.svh"

module secant_lut (
        input  logic                   clk,
        input  logic                   arst_n,
        input  logic [1:0]             quad,
        input  logic                   enable,
        input  logic [`TRIG_REF_W-1:0] ref_angle,
        output trig_pkg::ieee_double_u data
);
        import trig_pkg::*;

        logic [62:0]  mag;
        logic         hit;
        ieee_double_u nxt;

        // secant is negative in the second and third quadrants.
        assign hit = (ref_angle <= `TRIG_RIGHT_ANGLE);

        always_comb
        begin
                case (ref_angle)
                0  : mag = 63'h3ff0000000000000;
                1  : mag = 63'h3ff0009fba3f7835;
                2  : mag = 63'h3ff0027f274d432f;
                3  : mag = 63'h3ff0059f0252e0bc;
                4  : mag = 63'h3ff00a008406617c;
                5  : mag = 63'h3ff00fa563d53203;
                6  : mag = 63'h3ff0168fd9895209;
                7  : mag = 63'h3ff01ec29f6be927;
                8  : mag = 63'h3ff02840f4e91085;
                9  : mag = 63'h3ff0330ea1b99998;
                10 : mag = 63'h3ff03f2ff9989907;
                11 : mag = 63'h3ff04ca9e08b8cb6;
                12 : mag = 63'h3ff05b81cfc51885;
                13 : mag = 63'h3ff06bbddb2b91b8;
                14 : mag = 63'h3ff07d64b78dea34;
                15 : mag = 63'h3ff0907dc1930690;
                16 : mag = 63'h3ff0a51105712a50;
                17 : mag = 63'h3ff0bb27477cf20f;
                18 : mag = 63'h3ff0d2ca0da1530d;
                19 : mag = 63'h3ff0ec03a9d451e4;
                20 : mag = 63'h3ff106df459ea072;
                21 : mag = 63'h3ff12368eecf1f68;
                22 : mag = 63'h3ff141ada5766662;
                23 : mag = 63'h3ff161bb6b4a03f3;
                24 : mag = 63'h3ff183a154932d8b;
                25 : mag = 63'h3ff1a76f9ad128b7;
                26 : mag = 63'h3ff1cd37b13ce9c7;
                27 : mag = 63'h3ff1f50c5b61511e;
                28 : mag = 63'h3ff21f01c602373c;
                29 : mag = 63'h3ff24b2da2943b49;
                30 : mag = 63'h3ff279a74590331c;
                31 : mag = 63'h3ff2aa87c7f7612a;
                32 : mag = 63'h3ff2ddea2c696f6a;
                33 : mag = 63'h3ff313eb883ae676;
                34 : mag = 63'h3ff34cab310ac280;
                35 : mag = 63'h3ff3884aef684af8;
                36 : mag = 63'h3ff3c6ef372fe94f;
                37 : mag = 63'h3ff408bf665efb99;
                38 : mag = 63'h3ff44de60b3c3d86;
                39 : mag = 63'h3ff4969132d53891;
                40 : mag = 63'h3ff4e2f2c0fa463b;
                41 : mag = 63'h3ff53340d31354d4;
                42 : mag = 63'h3ff587b62f6162b3;
                43 : mag = 63'h3ff5e092c2857578;
                44 : mag = 63'h3ff63e1c2d781ad9;
                45 : mag = 63'h3ff6a09e667f3bcc;
                46 : mag = 63'h3ff7086c7026f77d;
                47 : mag = 63'h3ff775e129d20b11;
                48 : mag = 63'h3ff7e9603e24eb24;
                49 : mag = 63'h3ff863573463a808;
                50 : mag = 63'h3ff8e43eaadf9333;
                51 : mag = 63'h3ff96c9bc1d2abfe;
                52 : mag = 63'h3ff9fd01bf93f3a3;
                53 : mag = 63'h3ffa9613f8fd7861;
                54 : mag = 63'h3ffb38880b4603e4;
                55 : mag = 63'h3ffbe52877982345;
                56 : mag = 63'h3ffc9cd7b485648a;
                57 : mag = 63'h3ffd6093ce555fa5;
                58 : mag = 63'h3ffe317ab5700fce;
                59 : mag = 63'h3fff10cf62336e2d;
                60 : mag = 63'h3ffffffffffffffe;
                61 : mag = 63'h40008056af82561c;
                62 : mag = 63'h40010a59ff3c94be;
                63 : mag = 63'h40019f1b8c9526ef;
                64 : mag = 63'h40023fd71f682340;
                65 : mag = 63'h4002edfb187b1137;
                66 : mag = 63'h4003ab32fb93a3a4;
                67 : mag = 63'h40047974b96de77f;
                68 : mag = 63'h40055b11998752bf;
                69 : mag = 63'h400652cbf905707c;
                70 : mag = 63'h400763f38fb4cf92;
                71 : mag = 63'h4008928aa26c4c06;
                72 : mag = 63'h4009e3779b97f4a7;
                73 : mag = 63'h400b5cc824ec982d;
                74 : mag = 63'h400d060d6ac58d68;
                75 : mag = 63'h400ee8dd4748bf16;
                76 : mag = 63'h401088c56499f43a;
                77 : mag = 63'h4011c819f29be021;
                78 : mag = 63'h40133d2b00047f05;
                79 : mag = 63'h4014f69f907046fe;
                80 : mag = 63'h401708fb2129168b;
                81 : mag = 63'h401991df41de341a;
                82 : mag = 63'h401cbdbe5febffaf;
                83 : mag = 63'h402069387b617567;
                84 : mag = 63'h4023222ff85e6006;
                85 : mag = 63'h4026f28a8ae3aafa;
                86 : mag = 63'h402cabd2100d0374;
                87 : mag = 63'h40331b797e990db2;
                88 : mag = 63'h403ca7596e271c6c;
                89 : mag = 63'h404ca63b6cba7b49;
                90 : mag = 63'h7ff0000000000000;   // infinity.
                default : mag = '0;
                endcase

                nxt.raw         = {1'b0, mag};
                nxt.fields.sign = hit & ((quad == 2'd1) || (quad == 2'd2));
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                        data <= '0;
                else if (enable)
                        data <= nxt;                 // holds while enable is low.
        end

endmodule

// ==== logic/trig_ctrl.sv ====
`timescale 1ns/1ps

module trig_ctrl (
        input  logic                   clk,
        input  logic                   arst_n,
        input  logic                   start,
        input  trig_pkg::trig_func_t   func,
        input  logic                   red_valid,
        input  logic                   in_range,
        input  trig_pkg::ieee_double_u sec_data,
        input  trig_pkg::ieee_double_u cos_data,
        output trig_pkg::ieee_double_u result,
        output logic                   done,
        output logic                   range_err
);
        import trig_pkg::*;

        trig_func_t   func_d1;
        trig_func_t   func_d2;
        logic         range_d;
        logic         valid_d;
        ieee_double_u picked;

        // func is captured with start and shifted once more, so that
        // func_d2 and range_d sit next to the table data.
        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        func_d1 <= func_cos;
                        func_d2 <= func_cos;
                        range_d <= 1'b0;
                end
                else
                begin
                        if (start)
                                func_d1 <= func;
                        func_d2 <= func_d1;
                        range_d <= in_range;
                end
        end

        assign picked = (func_d2 == func_cos) ? cos_data : sec_data;

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        valid_d   <= 1'b0;
                        done      <= 1'b0;
                        range_err <= 1'b0;
                        result    <= '0;
                end
                else
                begin
                        valid_d   <= red_valid;         // tables load on this same edge.
                        done      <= valid_d;
                        range_err <= valid_d & ~range_d;
                        if (valid_d)
                                result.raw <= range_d ? picked.raw : 64'd0;
                end
        end

endmodule

// ==== logic/trig_params.svh ====
`ifndef TRIG_PARAMS_SVH
`define TRIG_PARAMS_SVH

// width of the degree input word.
`define TRIG_ANGLE_W 32

`define TRIG_FULL_TURN 360   // first angle that is rejected.
`define TRIG_RIGHT_ANGLE 90  // quadrant size and largest reference angle.

// holds a reference angle of 0 to 90.
`define TRIG_REF_W 7

`endif

// ==== logic/trig_pkg.sv ====
package trig_pkg;

        // binary64 layout, sign in the top bit.
        typedef struct packed {
                logic        sign;
                logic [10:0] exponent;
                logic [51:0] mantissa;
        } ieee_double_s;

        // the same word either as raw bits or split into its fields.
        typedef union packed {
                logic [63:0]  raw;
                ieee_double_s fields;
        } ieee_double_u;

        typedef enum logic {
                func_cos = 1'b0,
                func_sec = 1'b1
        } trig_func_t;

endpackage

// ==== logic/trig_top.sv ====
`timescale 1ns/1ps
`include "trig_params.svh"

module trig_top (
        input  logic                     clk,
        input  logic                     arst_n,
        input  logic                     start,
        input  logic [`TRIG_ANGLE_W-1:0] degrees,
        input  trig_pkg::trig_func_t     func,
        output trig_pkg::ieee_double_u   result,
        output logic                     done,
        output logic                     range_err
);
        import trig_pkg::*;

        logic [1:0]             quad;
        logic [`TRIG_REF_W-1:0] ref_angle;
        logic                   in_range;
        logic                   red_valid;
        ieee_double_u           sec_data;
        ieee_double_u           cos_data;

        angle_reducer u_reducer (
                .clk       (clk),
                .arst_n    (arst_n),
                .start     (start),
                .degrees   (degrees),
                .quad      (quad),
                .ref_angle (ref_angle),
                .in_range  (in_range),
                .red_valid (red_valid)
        );

        // both tables look up every request, the control picks one.
        secant_lut u_sec (
                .clk       (clk),
                .arst_n    (arst_n),
                .quad      (quad),
                .enable    (red_valid),
                .ref_angle (ref_angle),
                .data      (sec_data)
        );

        cosine_lut u_cos (
                .clk       (clk),
                .arst_n    (arst_n),
                .quad      (quad),
                .enable    (red_valid),
                .ref_angle (ref_angle),
                .data      (cos_data)
        );

        trig_ctrl u_ctrl (
                .clk       (clk),
                .arst_n    (arst_n),
                .start     (start),
                .func      (func),
                .red_valid (red_valid),
                .in_range  (in_range),
                .sec_data  (sec_data),
                .cos_data  (cos_data),
                .result    (result),
                .done      (done),
                .range_err (range_err)
        );

endmodule

// ==== testbench/trig_tb.sv ====
`timescale 1ns/1ps
`include "trig_params.svh"

module trig_tb;
        import trig_pkg::*;

        localparam real PI = 3.14159265358979323846;
        localparam logic [31:0] DIRECTED [12] = '{0, 1, 89, 90, 91, 180, 269, 270, 359,
                                                   360, 32'h8000_0000, 32'hffff_ffff};

        logic                     clk = 1'b0;
        logic                     arst_n;
        logic                     start;
        logic [`TRIG_ANGLE_W-1:0] degrees;
        trig_func_t               func;
        ieee_double_u             result;
        logic                     done;
        logic                     range_err;

        logic [31:0]              rng_state = 32'h98c4;
        int unsigned              cycle = 0;

        // expected responses with the oldest request at the front.
        ieee_double_u             q_value[$];
        real                      q_tol[$];
        logic                     q_sign[$];
        logic                     q_range[$];
        int unsigned              q_cycle[$];
        logic [`TRIG_ANGLE_W-1:0] q_angle[$];

        trig_top uut (
                .clk       (clk),
                .arst_n    (arst_n),
                .start     (start),
                .degrees   (degrees),
                .func      (func),
                .result    (result),
                .done      (done),
                .range_err (range_err)
        );

        always #4 clk = ~clk;

        always @(posedge clk)
                cycle <= cycle + 1;

        function automatic logic [31:0] next_rand();
                rng_state = rng_state * 32'd1664525 + 32'd1013904223;
                return rng_state;
        endfunction

        task automatic abort_run();
                $display("CHECKS FAILED");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic check_value(input string name, input ieee_double_u got,
                                   input ieee_double_u exp, input real tol);
                real  got_mag;
                real  exp_mag;
                real  diff;
                logic bad;
                got_mag = $bitstoreal({1'b0, got.raw[62:0]});
                exp_mag = $bitstoreal({1'b0, exp.raw[62:0]});
                if ($isunknown(got.raw))
                        bad = 1'b1;
                else if (exp.fields.exponent == 11'h7ff)
                        bad = (got.fields.exponent != 11'h7ff) || (got.fields.mantissa != 52'd0);
                else if (tol == 0.0)
                        bad = (got.raw[62:0] != exp.raw[62:0]);
                else
                begin
                        diff = (got_mag > exp_mag) ? got_mag - exp_mag : exp_mag - got_mag;
                        bad  = (got.fields.exponent == 11'h7ff) || (diff > tol * exp_mag);
                end
                if (bad)
                begin
                        $display("ERR %s got=%h exp=%h", name, got.raw, exp.raw);
                        abort_run();
                end
        endtask

        task automatic check_sign(input string name, input logic got, input logic exp);
                if (got !== exp)
                begin
                        $display("ERR %s got=%h exp=%h", name, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                if (got !== exp)
                begin
                        $display("ERR %s got=%h exp=%h", name, got, exp);
                        abort_run();
                end
        endtask

        // the reference model folds the angle and works the result out in real arithmetic.
        task automatic push_expected(input logic [`TRIG_ANGLE_W-1:0] angle, input trig_func_t f);
                int unsigned  quad_m;
                int unsigned  ref_m;
                real          cos_m;
                real          tol;
                logic         sign_m;
                ieee_double_u exp_v;
                tol       = 0.0;
                sign_m    = 1'b0;
                exp_v.raw = 64'd0;
                if (angle < 360)
                begin
                        quad_m = angle / 90;
                        case (quad_m)
                        0 : ref_m = angle;
                        1 : ref_m = 180 - angle;
                        2 : ref_m = angle - 180;
                        default : ref_m = 360 - angle;
                        endcase
                        sign_m = (quad_m == 1) || (quad_m == 2);
                        cos_m  = $cos(ref_m * PI / 180.0);
                        if (ref_m == 90)
                                exp_v.raw = (f == func_sec) ? 64'h7ff0_0000_0000_0000 : 64'd0;
                        else if (f == func_cos)
                        begin
                                exp_v.raw = $realtobits(cos_m);
                                tol       = 1.0e-12;
                        end
                        else
                        begin
                                exp_v.raw = $realtobits(1.0 / cos_m);  // secant times cosine is one.
                                tol       = 1.0e-9;
                        end
                        exp_v.fields.sign = sign_m;
                end
                q_value.push_back(exp_v);
                q_tol.push_back(tol);
                q_sign.push_back(sign_m);
                q_range.push_back(angle >= 360);
                q_cycle.push_back(cycle + 1);     // the counter steps on this same edge.
                q_angle.push_back(angle);
        endtask

        task automatic send_request(input logic [`TRIG_ANGLE_W-1:0] angle, input trig_func_t f);
                @(posedge clk);
                start   <= 1'b1;
                degrees <= angle;
                func    <= f;
                push_expected(angle, f);
        endtask

        task automatic idle_cycles(input int n);
                repeat (n)
                begin
                        @(posedge clk);
                        start <= 1'b0;
                end
        endtask

        always @(negedge clk)
        begin
                if (done)
                begin
                        if (q_cycle.size() == 0)
                        begin
                                $display("done pulsed with no request in flight");
                                abort_run();
                        end
                        else
                        begin
                                if (cycle - q_cycle[0] != 3)
                                begin
                                        $display("done for angle %0d came %0d cycles after start",
                                                 q_angle[0], cycle - q_cycle[0]);
                                        abort_run();
                                end
                                check_flag("range_err", range_err, q_range[0]);
                                check_sign("result.sign", result.fields.sign, q_sign[0]);
                                check_value("result", result, q_value[0], q_tol[0]);
                                void'(q_value.pop_front());
                                void'(q_tol.pop_front());
                                void'(q_sign.pop_front());
                                void'(q_range.pop_front());
                                void'(q_cycle.pop_front());
                                void'(q_angle.pop_front());
                        end
                end
                else if (q_cycle.size() != 0 && cycle - q_cycle[0] > 16)
                begin
                        $display("done never came for angle %0d", q_angle[0]);
                        abort_run();
                end
        end

        initial
        begin
                int unsigned              i;
                int unsigned              wait_cnt;
                logic [31:0]              r;
                logic [`TRIG_ANGLE_W-1:0] angle;
                ieee_double_u             zero_v;
                zero_v.raw = 64'd0;
                arst_n     = 1'b0;
                start      = 1'b0;
                degrees    = '0;
                func       = func_cos;
                repeat (10) @(posedge clk);
                arst_n <= 1'b1;

                // nothing has been started, so the outputs stay quiet.
                repeat (4)
                begin
                        @(negedge clk);
                        check_flag("done", done, 1'b0);
                        check_flag("range_err", range_err, 1'b0);
                        check_sign("result.sign", result.fields.sign, 1'b0);
                        check_value("result", result, zero_v, 0.0);
                end

                for (i = 0; i < 12; i++)
                begin
                        send_request(DIRECTED[i], func_cos);
                        send_request(DIRECTED[i], func_sec);
                end
                idle_cycles(5);

                for (i = 0; i < 400; i++)
                begin
                        r = next_rand();
                        if (r[31:28] == 4'd0)
                                angle = 360 + r[23:0];
                        else if (r[31:28] == 4'd1)
                                angle = 32'hffff_0000 | {16'd0, r[23:8]};  // top of the word.
                        else
                                angle = r[26:8] % 360;
                        send_request(angle, trig_func_t'(r[27]));
                        r = next_rand();
                        idle_cycles((r[31:29] < 3'd5) ? 0 : r[31:29] - 3'd4);
                end
                idle_cycles(1);

                wait_cnt = 0;
                while (q_cycle.size() != 0)
                begin
                        @(posedge clk);
                        wait_cnt++;
                        if (wait_cnt > 20)
                        begin
                                $display("timeout: done never came for %0d requests",
                                         q_cycle.size());
                                abort_run();
                        end
                end
                $display("ALL CHECKS PASSED");
                $finish;
        end

endmodule

// ==== trig_table.f ====
+incdir+logic
logic/trig_pkg.sv
logic/angle_reducer.sv
logic/secant_lut.sv
logic/cosine_lut.sv
logic/trig_ctrl.sv
logic/trig_top.sv
testbench/trig_tb.sv
